// ==== design/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

    localparam int xlen        = 32;
    localparam int block_bits  = 64;
    localparam int offset_bits = 3;    // byte offset within a line

    typedef logic [xlen-offset_bits-1:0] line_addr_t;
    typedef logic [block_bits-1:0]       block_t;
    typedef logic [3:0]                  mem_tag_t;    // zero means no tag

    typedef enum logic {
        mem_read,
        mem_write
    } mem_op_e;

    typedef enum logic [1:0] {
        size_byte,
        size_half,
        size_word
    } mem_size_e;

    typedef enum logic [1:0] {
        bus_none  = 2'd0,
        bus_load  = 2'd1,
        bus_store = 2'd2
    } bus_command_e;

    // controller states
    typedef enum logic {
        ready,
        wait_fill
    } dc_state_e;

    function automatic line_addr_t line_of(input logic [xlen-1:0] addr);
        return addr[xlen-1:offset_bits];
    endfunction

    function automatic logic [offset_bits-1:0] offset_of(input logic [xlen-1:0] addr);
        return addr[offset_bits-1:0];
    endfunction

    // first byte address of a line
    function automatic logic [xlen-1:0] line_base(input line_addr_t line);
        return {line, {offset_bits{1'b0}}};
    endfunction

endpackage

`default_nettype wire

// ==== design/lookup_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface lookup_if import dcache_pkg::*; ();

    line_addr_t addr;
    logic       access;       // request in flight, on a main cache fill it marks a store
    logic       write_en;
    block_t     write_block;
    logic       hit;          // combinational on addr
    block_t     hit_block;

    modport ctrl (
        output addr, access, write_en, write_block,
        input  hit, hit_block
    );

    modport array (
        input  addr, access, write_en, write_block,
        output hit, hit_block
    );

endinterface

`default_nettype wire

// ==== design/line_xfer_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// one-cycle line strobe, receiver has to take it
interface line_xfer_if import dcache_pkg::*; ();

    logic       valid;
    line_addr_t addr;
    block_t     block;
    logic       dirty;

    modport source (
        output valid, addr, block, dirty
    );

    modport sink (
        input valid, addr, block, dirty
    );

endinterface

`default_nettype wire

// ==== design/main_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module main_cache import dcache_pkg::*; #(
    parameter int n_sets = 16
) (
    input  logic        clock,
    input  logic        reset,
    lookup_if.array     port,
    line_xfer_if.source evict
);

    localparam int index_bits = $clog2(n_sets);
    localparam int tag_bits   = $bits(line_addr_t) - index_bits;

    logic [tag_bits-1:0] tag_mem [n_sets];
    block_t              data_mem [n_sets];
    logic [n_sets-1:0]   valid_bits;
    logic [n_sets-1:0]   dirty_bits;

    logic [index_bits-1:0] index;
    logic [tag_bits-1:0]   tag;
    logic                  match;

    assign index = port.addr[index_bits-1:0];
    assign tag   = port.addr[$bits(line_addr_t)-1:index_bits];
    assign match = valid_bits[index] && (tag_mem[index] == tag);

    assign port.hit       = match;
    assign port.hit_block = data_mem[index];

    // allocating over a valid line pushes the old one out
    assign evict.valid = port.write_en && !match && valid_bits[index];
    assign evict.addr  = {tag_mem[index], index};    // rebuilt line address
    assign evict.block = data_mem[index];
    assign evict.dirty = dirty_bits[index];

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_bits <= '0;
            dirty_bits <= '0;
        end else if (port.write_en) begin
            valid_bits[index] <= 1'b1;
            if (match) begin
                dirty_bits[index] <= 1'b1;            // store hit
            end else begin
                dirty_bits[index] <= port.access;     // fill, dirty only for a store miss
            end
        end
    end

    always_ff @(posedge clock) begin
        if (port.write_en) begin
            data_mem[index] <= port.write_block;
            if (!match) begin
                tag_mem[index] <= tag;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/victim_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module victim_cache import dcache_pkg::*; #(
    parameter int n_victim = 4
) (
    input  logic        clock,
    input  logic        reset,
    lookup_if.array     port,
    line_xfer_if.sink   insert,
    line_xfer_if.source castout
);

    localparam int idx_bits = (n_victim > 1) ? $clog2(n_victim) : 1;

    line_addr_t          entry_addr [n_victim];
    block_t              entry_block [n_victim];
    logic [n_victim-1:0] entry_valid;
    logic [n_victim-1:0] entry_dirty;
    logic [idx_bits-1:0] entry_age [n_victim];    // larger is more recent

    logic                hit_any;
    logic [idx_bits-1:0] hit_idx;
    logic                full;
    logic                free_found;
    logic [idx_bits-1:0] free_idx;
    logic [idx_bits-1:0] lru_idx;
    logic [idx_bits-1:0] min_age;
    logic [idx_bits-1:0] slot;

    // full address search
    always_comb begin
        hit_any = 1'b0;
        hit_idx = '0;
        for (int i = 0; i < n_victim; i++) begin
            if (entry_valid[i] && (entry_addr[i] == port.addr)) begin
                hit_any = 1'b1;
                hit_idx = idx_bits'(i);
            end
        end
    end

    // placement: first free entry, else the oldest one
    always_comb begin
        free_found = 1'b0;
        free_idx   = '0;
        lru_idx    = '0;
        min_age    = entry_age[0];
        for (int i = 0; i < n_victim; i++) begin
            if (!entry_valid[i] && !free_found) begin
                free_found = 1'b1;
                free_idx   = idx_bits'(i);
            end
            if (entry_age[i] < min_age) begin
                min_age = entry_age[i];
                lru_idx = idx_bits'(i);
            end
        end
    end

    assign full = &entry_valid;
    assign slot = full ? lru_idx : free_idx;

    assign port.hit       = hit_any;
    assign port.hit_block = entry_block[hit_idx];

    // clean lines are simply dropped
    assign castout.valid = insert.valid && full && entry_dirty[lru_idx];
    assign castout.addr  = entry_addr[lru_idx];
    assign castout.block = entry_block[lru_idx];
    assign castout.dirty = entry_dirty[lru_idx];

    always_ff @(posedge clock) begin
        if (reset) begin
            entry_valid <= '0;
            entry_dirty <= '0;
            for (int i = 0; i < n_victim; i++) begin
                entry_age[i] <= '0;
            end
        end else if (insert.valid) begin
            for (int i = 0; i < n_victim; i++) begin
                if (idx_bits'(i) == slot) begin
                    entry_valid[i] <= 1'b1;
                    entry_dirty[i] <= insert.dirty;
                    entry_age[i]   <= '1;
                end else if (entry_age[i] != '0) begin
                    entry_age[i] <= entry_age[i] - 1'b1;
                end
            end
        end else if (port.access && hit_any) begin
            for (int i = 0; i < n_victim; i++) begin
                if (idx_bits'(i) == hit_idx) begin
                    entry_age[i] <= '1;
                end else if (entry_age[i] != '0) begin
                    entry_age[i] <= entry_age[i] - 1'b1;
                end
            end
            if (port.write_en) begin
                entry_dirty[hit_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (insert.valid) begin
            entry_addr[slot]  <= insert.addr;
            entry_block[slot] <= insert.block;
        end else if (port.write_en && hit_any) begin
            entry_block[hit_idx] <= port.write_block;    // store hit
        end
    end

endmodule

`default_nettype wire

// ==== design/miss_handler.sv ====
`timescale 1ns/1ps
`default_nettype none

module miss_handler import dcache_pkg::*; (
    input  logic             clock,
    input  logic             reset,
    input  logic             fetch_start,
    input  line_addr_t       fetch_addr,
    output logic             fill_valid,
    output block_t           fill_block,
    line_xfer_if.sink        castout,
    output bus_command_e     mem_command,
    output logic [xlen-1:0]  mem_addr,
    output block_t           mem_wdata,
    input  mem_tag_t         mem_response,
    input  block_t           mem_rdata,
    input  mem_tag_t         mem_tag
);

    // write-back buffer
    logic       wb_valid;
    line_addr_t wb_addr;
    block_t     wb_block;

    // the single outstanding load
    logic       load_pending;    // not yet accepted by memory
    line_addr_t load_addr;
    mem_tag_t   load_tag;        // zero while nothing is in flight

    logic accepted;
    logic take_castout;

    assign accepted     = (mem_response != '0);
    assign take_castout = castout.valid && castout.dirty;

    // buffered store goes first so memory is current when the load reads it
    always_comb begin
        mem_command = bus_none;
        mem_addr    = '0;
        mem_wdata   = '0;
        if (wb_valid) begin
            mem_command = bus_store;
            mem_addr    = line_base(wb_addr);
            mem_wdata   = wb_block;
        end else if (load_pending) begin
            mem_command = bus_load;
            mem_addr    = line_base(load_addr);
        end
    end

    assign fill_valid = (load_tag != '0) && (mem_tag == load_tag);
    assign fill_block = mem_rdata;

    always_ff @(posedge clock) begin
        if (reset) begin
            wb_valid     <= 1'b0;
            load_pending <= 1'b0;
            load_tag     <= '0;
        end else begin
            if (wb_valid && accepted) begin
                wb_valid <= 1'b0;    // store done on acceptance
            end
            if (take_castout) begin
                wb_valid <= 1'b1;
            end
            if (fetch_start) begin
                load_pending <= 1'b1;
            end else if (!wb_valid && load_pending && accepted) begin
                load_pending <= 1'b0;
                load_tag     <= mem_response;
            end
            if (fill_valid) begin
                load_tag <= '0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (take_castout) begin
            wb_addr  <= castout.addr;
            wb_block <= castout.block;
        end
        if (fetch_start) begin
            load_addr <= fetch_addr;
        end
    end

endmodule

`default_nettype wire

// ==== design/dcache_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_controller import dcache_pkg::*; (
    input  logic            clock,
    input  logic            reset,
    input  logic            req_valid,
    input  mem_op_e         req_op,
    input  mem_size_e       req_size,
    input  logic [xlen-1:0] req_addr,
    input  logic [xlen-1:0] req_wdata,
    output logic            stall,
    output logic            rsp_valid,
    output logic [xlen-1:0] rsp_data,
    lookup_if.ctrl          main_port,
    lookup_if.ctrl          victim_port,
    output logic            fetch_start,
    output line_addr_t      fetch_addr,
    input  logic            fill_valid,
    input  block_t          fill_block
);

    dc_state_e state;

    // request held over a miss
    mem_op_e         held_op;
    mem_size_e       held_size;
    logic [xlen-1:0] held_addr;
    logic [xlen-1:0] held_wdata;

    logic   accept;
    logic   any_hit;
    block_t hit_block;
    block_t merged_hit;
    block_t fill_line;

    // write the store bytes into a line, little endian within the line
    function automatic block_t merge_store(input block_t line, input logic [offset_bits-1:0] off,
                                           input mem_size_e size, input logic [xlen-1:0] data);
        block_t result;
        result = line;
        case (size)
            size_byte: result[{off, 3'b000} +: 8]         = data[7:0];
            size_half: result[{off[2:1], 4'b0000} +: 16]  = data[15:0];
            default:   result[{off[2], 5'b00000} +: 32]   = data;
        endcase
        return result;
    endfunction

    function automatic logic [xlen-1:0] load_data(input block_t line,
                                                  input logic [offset_bits-1:0] off,
                                                  input mem_size_e size);
        logic [xlen-1:0] result;
        case (size)
            size_byte: result = {24'b0, line[{off, 3'b000} +: 8]};    // zero extended
            size_half: result = {16'b0, line[{off[2:1], 4'b0000} +: 16]};
            default:   result = line[{off[2], 5'b00000} +: 32];
        endcase
        return result;
    endfunction

    assign accept    = (state == ready) && req_valid;
    assign any_hit   = main_port.hit || victim_port.hit;
    assign hit_block = main_port.hit ? main_port.hit_block : victim_port.hit_block;    // main first
    assign stall     = (state == wait_fill);

    assign fetch_start = accept && !any_hit;
    assign fetch_addr  = line_of(req_addr);

    assign merged_hit = merge_store(hit_block, offset_of(req_addr), req_size, req_wdata);
    assign fill_line  = (held_op == mem_write) ?
                        merge_store(fill_block, offset_of(held_addr), held_size, held_wdata) :
                        fill_block;

    // main cache sees the new request in ready and the held one during the fill
    assign main_port.addr        = (state == ready) ? line_of(req_addr) : line_of(held_addr);
    assign main_port.access      = (state == ready) ? req_valid : (held_op == mem_write);
    assign main_port.write_en    = (state == ready) ?
                                   (accept && main_port.hit && req_op == mem_write) : fill_valid;
    assign main_port.write_block = (state == ready) ? merged_hit : fill_line;

    assign victim_port.addr        = line_of(req_addr);
    assign victim_port.access      = accept;
    assign victim_port.write_en    = accept && !main_port.hit && victim_port.hit &&
                                     (req_op == mem_write);
    assign victim_port.write_block = merged_hit;

    always_ff @(posedge clock) begin
        if (reset) begin
            state     <= ready;
            rsp_valid <= 1'b0;
        end else begin
            case (state)
                ready: begin
                    rsp_valid <= accept && any_hit;
                    if (accept && !any_hit) begin
                        state <= wait_fill;
                    end
                end
                wait_fill: begin
                    rsp_valid <= fill_valid;
                    if (fill_valid) begin
                        state <= ready;
                    end
                end
                default: state <= ready;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            held_op    <= req_op;
            held_size  <= req_size;
            held_addr  <= req_addr;
            held_wdata <= req_wdata;
        end
        if (accept && any_hit) begin
            rsp_data <= (req_op == mem_read) ?
                        load_data(hit_block, offset_of(req_addr), req_size) : '0;
        end else if (state == wait_fill && fill_valid) begin
            rsp_data <= (held_op == mem_read) ?
                        load_data(fill_block, offset_of(held_addr), held_size) : '0;
        end
    end

endmodule

`default_nettype wire

// ==== design/dcache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_top import dcache_pkg::*; #(
    parameter int n_sets   = 16,
    parameter int n_victim = 4
) (
    input  logic            clock,
    input  logic            reset,
    // pipeline side
    input  logic            req_valid,
    input  mem_op_e         req_op,
    input  mem_size_e       req_size,
    input  logic [xlen-1:0] req_addr,
    input  logic [xlen-1:0] req_wdata,
    output logic            stall,
    output logic            rsp_valid,
    output logic [xlen-1:0] rsp_data,
    // memory side
    output bus_command_e    mem_command,
    output logic [xlen-1:0] mem_addr,
    output block_t          mem_wdata,
    input  mem_tag_t        mem_response,
    input  block_t          mem_rdata,
    input  mem_tag_t        mem_tag
);

    lookup_if    main_port ();
    lookup_if    victim_port ();
    line_xfer_if evict_xfer ();      // main cache to victim cache
    line_xfer_if castout_xfer ();    // victim cache to write-back buffer

    logic       fetch_start;
    line_addr_t fetch_addr;
    logic       fill_valid;
    block_t     fill_block;

    dcache_controller ctrl_i (
        .clock       (clock),
        .reset       (reset),
        .req_valid   (req_valid),
        .req_op      (req_op),
        .req_size    (req_size),
        .req_addr    (req_addr),
        .req_wdata   (req_wdata),
        .stall       (stall),
        .rsp_valid   (rsp_valid),
        .rsp_data    (rsp_data),
        .main_port   (main_port.ctrl),
        .victim_port (victim_port.ctrl),
        .fetch_start (fetch_start),
        .fetch_addr  (fetch_addr),
        .fill_valid  (fill_valid),
        .fill_block  (fill_block)
    );

    main_cache #(
        .n_sets (n_sets)
    ) main_i (
        .clock (clock),
        .reset (reset),
        .port  (main_port.array),
        .evict (evict_xfer.source)
    );

    victim_cache #(
        .n_victim (n_victim)
    ) victim_i (
        .clock   (clock),
        .reset   (reset),
        .port    (victim_port.array),
        .insert  (evict_xfer.sink),
        .castout (castout_xfer.source)
    );

    miss_handler miss_i (
        .clock        (clock),
        .reset        (reset),
        .fetch_start  (fetch_start),
        .fetch_addr   (fetch_addr),
        .fill_valid   (fill_valid),
        .fill_block   (fill_block),
        .castout      (castout_xfer.sink),
        .mem_command  (mem_command),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_response (mem_response),
        .mem_rdata    (mem_rdata),
        .mem_tag      (mem_tag)
    );

endmodule

`default_nettype wire

// ==== sim/memory_model.sv ====
`timescale 1ns/1ps
`default_nettype none

// tagged memory over a 4 KiB window, every command is accepted at once
module memory_model import dcache_pkg::*; #(
    parameter int latency = 3
) (
    input  logic         clock,
    input  logic         reset,
    input  bus_command_e mem_command,
    input  logic [xlen-1:0] mem_addr,
    input  block_t       mem_wdata,
    output mem_tag_t     mem_response,
    output block_t       mem_rdata,
    output mem_tag_t     mem_tag,
    output int           load_count,
    output int           store_count
);

    localparam int lines = 512;

    block_t     mem [lines];
    line_addr_t store_log [64];    // line addresses of stores, in bus order

    mem_tag_t next_tag;
    mem_tag_t pend_tag;
    block_t   pend_data;
    int       countdown;

    function automatic block_t fill_pattern(input line_addr_t line);
        return {{3'b0, line} ^ 32'ha5c3_0f1e, {3'b0, line} * 32'h0001_0203 + 32'h1357_9bdf};
    endfunction

    initial begin
        for (int i = 0; i < lines; i++) begin
            mem[i] = fill_pattern(29'(i));
        end
    end

    assign mem_response = (mem_command != bus_none) ? next_tag : 4'h0;

    always @(posedge clock) begin
        if (reset) begin
            next_tag    <= 4'h1;
            countdown   <= 0;
            mem_tag     <= 4'h0;
            mem_rdata   <= '0;
            load_count  <= 0;
            store_count <= 0;
        end else begin
            mem_tag <= 4'h0;
            if (countdown != 0) begin
                countdown <= countdown - 1;
                if (countdown == 1) begin
                    mem_tag   <= pend_tag;    // read data returns with its tag
                    mem_rdata <= pend_data;
                end
            end
            if (mem_command == bus_store) begin
                mem[mem_addr[11:3]] <= mem_wdata;
                if (store_count < 64) begin
                    store_log[store_count[5:0]] <= mem_addr[31:3];
                end
                store_count <= store_count + 1;
            end else if (mem_command == bus_load) begin
                pend_data  <= mem[mem_addr[11:3]];
                pend_tag   <= next_tag;
                countdown  <= latency;
                load_count <= load_count + 1;
            end
            if (mem_command != bus_none) begin
                next_tag <= (next_tag == 4'hf) ? 4'h1 : next_tag + 4'h1;    // never zero
            end
        end
    end

endmodule

`default_nettype wire

// ==== sim/dcache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_tb import dcache_pkg::*; ();

    localparam int n_sets       = 16;
    localparam int n_victim     = 4;
    localparam int window_lines = 512;    // 4 KiB of addresses
    localparam int max_wait     = 200;

    logic            clock;
    logic            reset;
    logic            req_valid;
    mem_op_e         req_op;
    mem_size_e       req_size;
    logic [xlen-1:0] req_addr;
    logic [xlen-1:0] req_wdata;
    logic            stall;
    logic            rsp_valid;
    logic [xlen-1:0] rsp_data;
    bus_command_e    mem_command;
    logic [xlen-1:0] mem_addr;
    block_t          mem_wdata;
    mem_tag_t        mem_response;
    block_t          mem_rdata;
    mem_tag_t        mem_tag;
    int              load_count;
    int              store_count;

    logic [63:0] shadow [window_lines];    // what a perfect memory holds
    int          errors;
    int          checks;
    logic        timed_out;

    dcache_top #(.n_sets(n_sets), .n_victim(n_victim)) dut_i (
        .clock(clock), .reset(reset),
        .req_valid(req_valid), .req_op(req_op), .req_size(req_size),
        .req_addr(req_addr), .req_wdata(req_wdata),
        .stall(stall), .rsp_valid(rsp_valid), .rsp_data(rsp_data),
        .mem_command(mem_command), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .mem_response(mem_response), .mem_rdata(mem_rdata), .mem_tag(mem_tag)
    );

    memory_model mem_i (
        .clock(clock), .reset(reset),
        .mem_command(mem_command), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .mem_response(mem_response), .mem_rdata(mem_rdata), .mem_tag(mem_tag),
        .load_count(load_count), .store_count(store_count)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    function automatic logic [63:0] fill_pattern(input logic [28:0] line);
        return {{3'b0, line} ^ 32'ha5c3_0f1e, {3'b0, line} * 32'h0001_0203 + 32'h1357_9bdf};
    endfunction

    function automatic int size_bytes(input mem_size_e size);
        return (size == size_byte) ? 1 : (size == size_half) ? 2 : 4;
    endfunction

    // reference for a load with zero extension
    function automatic logic [31:0] expected_load(input logic [31:0] addr, input mem_size_e size);
        logic [63:0] line;
        logic [31:0] value;
        line  = shadow[addr[11:3]];
        value = '0;
        for (int k = 0; k < size_bytes(size); k++) begin
            value[8*k +: 8] = line[8*(int'(addr[2:0]) + k) +: 8];
        end
        return value;
    endfunction

    function automatic void apply_store(input logic [31:0] addr, input mem_size_e size,
                                        input logic [31:0] data);
        for (int k = 0; k < size_bytes(size); k++) begin
            shadow[addr[11:3]][8*(int'(addr[2:0]) + k) +: 8] = data[8*k +: 8];
        end
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("FAIL %s: got 0x%h, expected 0x%h at %0t", name, got, expected, $time);
        end
    endtask

    // one request from the falling edge that drives it to the end of its response
    task automatic do_access(input mem_op_e op, input mem_size_e size, input logic [31:0] addr,
                             input logic [31:0] wdata, output logic hit);
        logic [31:0] expected;
        int          cycles;
        hit = 1'b0;
        if (timed_out) return;
        expected  = (op == mem_read) ? expected_load(addr, size) : 32'h0;
        req_valid = 1'b1;
        req_op    = op;
        req_size  = size;
        req_addr  = addr;
        req_wdata = wdata;
        @(negedge clock);
        req_valid = 1'b0;
        if (rsp_valid) begin
            hit = 1'b1;
            check_value("stall", 64'(stall), 64'h0);
        end else begin
            check_value("stall", 64'(stall), 64'h1);    // miss stalls from here on
            cycles = 0;
            while (!rsp_valid && cycles < max_wait) begin
                @(negedge clock);
                cycles++;
            end
            if (!rsp_valid) begin
                $display("no response within %0d cycles for the access to address %h",
                         max_wait, addr);
                errors++;
                timed_out = 1'b1;
                return;
            end
            check_value("stall", 64'(stall), 64'h0);
        end
        check_value("rsp_data", 64'(rsp_data), 64'(expected));
        if (op == mem_write) begin
            apply_store(addr, size, wdata);
        end
        @(negedge clock);
        check_value("rsp_valid", 64'(rsp_valid), 64'h0);    // strobe lasts one cycle
    endtask

    // write-backs must carry the newest copy of their line
    always @(negedge clock) begin
        if (!reset && mem_command == bus_store) begin
            check_value("mem_wdata", mem_wdata, shadow[mem_addr[11:3]]);
        end
    end

    initial begin
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        was_hit;
        mem_op_e     op;
        mem_size_e   size;
        int          first_count;
        int          loads_before;
        int          cycles;
        int unsigned first_rand;
        first_rand = $urandom(32'h4be53b9e);
        errors     = 0;
        checks     = 0;
        timed_out  = 1'b0;
        reset      = 1'b1;
        req_valid  = 1'b0;
        req_op     = mem_read;
        req_size   = size_word;
        req_addr   = '0;
        req_wdata  = '0;
        for (int i = 0; i < window_lines; i++) begin
            shadow[i] = fill_pattern(29'(i));
        end
        repeat (8) @(negedge clock);
        reset = 1'b0;
        @(negedge clock);

        // everything idle once reset is gone
        check_value("stall", 64'(stall), 64'h0);
        check_value("rsp_valid", 64'(rsp_valid), 64'h0);
        check_value("mem_command", 64'(mem_command), 64'(bus_none));

        // dirty lines through set 5 so the two oldest are cast out in order
        first_count = store_count;
        for (int i = 0; i < n_victim + 3; i++) begin
            addr = {20'b0, 5'(i + 1), 4'd5, 3'b0};
            do_access(mem_write, size_word, addr, $urandom, was_hit);
        end
        cycles = 0;
        while (store_count - first_count < 2 && cycles < max_wait) begin
            @(negedge clock);
            cycles++;
        end
        if (store_count - first_count < 2) begin
            $display("cast-out lines did not reach memory within %0d cycles", max_wait);
        end
        check_value("store count", 64'(store_count - first_count), 64'h2);
        check_value("store_log", 64'(mem_i.store_log[first_count[5:0]]),
                    64'({20'b0, 5'd1, 4'd5}));
        check_value("store_log", 64'(mem_i.store_log[first_count[5:0] + 6'd1]),
                    64'({20'b0, 5'd2, 4'd5}));

        // two lines of set 9 in turn so the return hits the victim cache
        do_access(mem_read, size_word, {20'b0, 5'd1, 4'd9, 3'b0}, 32'h0, was_hit);
        do_access(mem_read, size_word, {20'b0, 5'd2, 4'd9, 3'b100}, 32'h0, was_hit);
        loads_before = load_count;
        do_access(mem_read, size_half, {20'b0, 5'd1, 4'd9, 3'b010}, 32'h0, was_hit);
        check_value("hit", 64'(was_hit), 64'h1);
        check_value("load count", 64'(load_count - loads_before), 64'h0);

        // store of each size and a read back
        for (int s = 0; s < 3; s++) begin
            size  = mem_size_e'(2'(s));
            addr  = $urandom & 32'h0000_0fff;
            addr  = addr & ~32'(size_bytes(size) - 1);
            wdata = $urandom;
            do_access(mem_write, size, addr, wdata, was_hit);
            do_access(mem_read, size, addr, 32'h0, was_hit);
            do_access(mem_read, size_word, addr & 32'hffff_fffc, 32'h0, was_hit);
        end

        // random mix of mostly loads
        for (int n = 0; n < 400; n++) begin
            size = mem_size_e'(2'($urandom % 3));
            op   = ($urandom % 4 == 0) ? mem_write : mem_read;
            addr = $urandom & 32'h0000_0fff;
            addr = addr & ~32'(size_bytes(size) - 1);
            do_access(op, size, addr, $urandom, was_hit);
        end

        $display("errors: %0d, checks: %0d", errors, checks);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
design/dcache_pkg.sv
design/lookup_if.sv
design/line_xfer_if.sv
design/main_cache.sv
design/victim_cache.sv
design/miss_handler.sv
design/dcache_controller.sv
design/dcache_top.sv
sim/memory_model.sv
sim/dcache_tb.sv

// ==== Makefile ====
# Verilator build and run of the data cache testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f sources.f --top-module dcache_tb -Mdir obj_dir
	@out="$$(./obj_dir/Vdcache_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir
